//--- hw/dcache_config.svh
/*
 Geometry of the data cache. The values are fixed: the modules
 assume two ways, one LRU bit per set and 32-bit words. Changing
 a width here without the matching RTL changes is not supported.
*/
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Data and address width
`define DC_WORD_W 32
// Byte offset within a 16-byte block
`define DC_OFFSET_W 4
// 16 sets
`define DC_INDEX_W 4
// Word within a block
`define DC_WORDSEL_W 2
// Address bits above index and offset
`define DC_TAG_W 24
`define DC_WAYS 2
`define DC_WORDS_PER_BLOCK 4
// One enable per byte lane
`define DC_BSEL_W 4

`endif

//--- hw/dcache_pkg.sv
/*
 Types shared by the cache blocks. Field widths follow the
 config header; the address split is tag, index, word, byte.
*/
`include "dcache_config.svh"

package dcache_pkg;

   // CPU address as the cache sees it
   typedef struct packed {
      logic [`DC_TAG_W-1:0]                tag;
      logic [`DC_INDEX_W-1:0]              index;
      logic [`DC_WORDSEL_W-1:0]            word;
      logic [`DC_OFFSET_W-`DC_WORDSEL_W-1:0] boff;
   } dc_adr_t;

   // Load/store request, held stable until ack
   typedef struct packed {
      dc_adr_t                adr;
      logic                   we;
      logic [`DC_BSEL_W-1:0]  be;
      logic [`DC_WORD_W-1:0]  wdat;
   } dc_cpu_req_t;

   // One way of one set
   typedef struct packed {
      logic                 dirty;
      logic                 valid;
      logic [`DC_TAG_W-1:0] tag;
   } dc_tag_entry_t;

   // Victim word on its way to memory
   typedef struct packed {
      logic [`DC_WORD_W-1:0] adr;
      logic [`DC_WORD_W-1:0] dat;
   } dc_dump_beat_t;

   typedef enum logic [1:0] {
      TAG_NONE  = 2'd0,
      TAG_TOUCH = 2'd1,
      TAG_FILL  = 2'd2,
      TAG_CLEAR = 2'd3
   } dc_tag_op_e;

   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      LOOKUP = 3'd1,
      DUMP   = 3'd2,
      REFILL = 3'd3,
      INVAL  = 3'd4
   } dc_state_e;

endpackage

//--- hw/dcache_tag_array.sv
/*
 Tag, valid, dirty and LRU store for a 2-way cache.
 Contents are not reset: the controller clears every set
 with TAG_CLEAR before the first lookup.
 Reads are registered; a write and a read of the same set
 in one cycle return the old entry.
*/
`include "dcache_config.svh"

module dcache_tag_array (
   input  logic                       clk,
   input  logic [`DC_INDEX_W-1:0]     rd_index_i,
   input  logic [`DC_TAG_W-1:0]       cmp_tag_i,
   input  dcache_pkg::dc_tag_op_e     op_i,
   input  logic [`DC_INDEX_W-1:0]     wr_index_i,
   input  logic [`DC_WAYS-1:0]        way_i,
   input  logic [`DC_TAG_W-1:0]       new_tag_i,
   input  logic                       dirty_i,
   output logic [`DC_WAYS-1:0]        hit_way_o,
   output logic [`DC_WAYS-1:0]        victim_way_o,
   output logic                       victim_dirty_o,
   output logic [`DC_TAG_W-1:0]       victim_tag_o
);
   import dcache_pkg::*;

   localparam int SETS = 1 << `DC_INDEX_W;

   dc_tag_entry_t tags_q [SETS][`DC_WAYS];
   // Set bit names way 1 as the next victim
   logic [SETS-1:0] lru_q;

   dc_tag_entry_t rd_entry_q [`DC_WAYS];
   logic          rd_lru_q;
   dc_tag_entry_t victim_entry;

   // ******************************
   // Update port
   // ******************************
   always_ff @(posedge clk) begin
      case (op_i)
         TAG_TOUCH: begin
            // Access keeps valid and tag, dirty only accumulates
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (way_i[w])
                  tags_q[wr_index_i][w].dirty <= tags_q[wr_index_i][w].dirty | dirty_i;
            end
            lru_q[wr_index_i] <= way_i[0];
         end
         TAG_FILL: begin
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (way_i[w])
                  tags_q[wr_index_i][w] <= '{dirty: dirty_i, valid: 1'b1, tag: new_tag_i};
            end
            // Freshly filled way becomes most recent
            lru_q[wr_index_i] <= way_i[0];
         end
         TAG_CLEAR: begin
            // Whole set goes, dirty data included
            for (int w = 0; w < `DC_WAYS; w++) begin
               tags_q[wr_index_i][w] <= '0;
            end
            lru_q[wr_index_i] <= 1'b0;
         end
         default: begin
         end
      endcase
   end

   // ******************************
   // Lookup port
   // ******************************
   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         rd_entry_q[w] <= tags_q[rd_index_i][w];
      end
      rd_lru_q <= lru_q[rd_index_i];
   end

   // Compare against the tag the controller holds
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         hit_way_o[w] = rd_entry_q[w].valid && (rd_entry_q[w].tag == cmp_tag_i);
      end
   end

   assign victim_way_o   = `DC_WAYS'(1) << rd_lru_q;
   assign victim_entry   = rd_entry_q[rd_lru_q];
   // Invalid entries never need a dump
   assign victim_dirty_o = victim_entry.valid & victim_entry.dirty;
   assign victim_tag_o   = victim_entry.tag;

   // A set never holds one tag in both ways
   a_hit_onehot: assert property (@(posedge clk) $onehot0(hit_way_o));

   a_way_onehot: assert property (@(posedge clk) (op_i != TAG_NONE) |-> $onehot(way_i));

endmodule

//--- hw/dcache_data_way.sv
/*
 Word store of one cache way, 16 sets of 4 words.
 Read data appears one cycle after the address is sampled.
 Writes merge by byte enable; no reset on the contents.
*/
`include "dcache_config.svh"

module dcache_data_way (
   input  logic                                  clk,
   input  logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0]  rd_adr_i,
   input  logic                                  we_i,
   input  logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0]  wr_adr_i,
   input  logic [`DC_BSEL_W-1:0]                 be_i,
   input  logic [`DC_WORD_W-1:0]                 wdat_i,
   output logic [`DC_WORD_W-1:0]                 rd_dat_o
);

   localparam int DEPTH = 1 << (`DC_INDEX_W + `DC_WORDSEL_W);

   logic [`DC_WORD_W-1:0] mem_q [DEPTH];

   // Byte lanes written independently
   always_ff @(posedge clk) begin
      if (we_i) begin
         for (int b = 0; b < `DC_BSEL_W; b++) begin
            if (be_i[b])
               mem_q[wr_adr_i][8*b +: 8] <= wdat_i[8*b +: 8];
         end
      end
   end

   // Registered read, old data on a same-cycle collision
   always_ff @(posedge clk) begin
      rd_dat_o <= mem_q[rd_adr_i];
   end

endmodule

//--- hw/dcache_ctrl.sv
/*
 Blocking write-back controller. One request at a time; a miss
 dumps a dirty victim, refills the block and looks up again.
 The memory must take every dump beat and return refill words
 in address order. Invalidate is served only in IDLE and drops
 dirty data of the set. Requests wait out 16 clear cycles after reset.
*/
`include "dcache_config.svh"

module dcache_ctrl (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cpu_req_valid_i,
   input  dcache_pkg::dc_cpu_req_t               cpu_req_i,
   output logic                                  cpu_ack_o,
   output logic [`DC_WORD_W-1:0]                 cpu_rdat_o,
   output logic                                  dump_valid_o,
   output dcache_pkg::dc_dump_beat_t             dump_o,
   output logic                                  refill_req_o,
   output logic [`DC_WORD_W-1:0]                 refill_adr_o,
   input  logic                                  refill_we_i,
   input  logic [`DC_WORD_W-1:0]                 refill_dat_i,
   input  logic                                  inv_stb_i,
   input  logic [`DC_WORD_W-1:0]                 inv_adr_i,
   output logic                                  inv_ack_o,
   output logic [`DC_INDEX_W-1:0]                tag_rd_index_o,
   output logic [`DC_TAG_W-1:0]                  tag_cmp_tag_o,
   output dcache_pkg::dc_tag_op_e                tag_op_o,
   output logic [`DC_INDEX_W-1:0]                tag_wr_index_o,
   output logic [`DC_WAYS-1:0]                   tag_way_o,
   output logic [`DC_TAG_W-1:0]                  tag_new_tag_o,
   output logic                                  tag_dirty_o,
   input  logic [`DC_WAYS-1:0]                   hit_way_i,
   input  logic [`DC_WAYS-1:0]                   victim_way_i,
   input  logic                                  victim_dirty_i,
   input  logic [`DC_TAG_W-1:0]                  victim_tag_i,
   output logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0]  way_rd_adr_o,
   output logic [`DC_WAYS-1:0]                   way_we_o,
   output logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0]  way_wr_adr_o,
   output logic [`DC_BSEL_W-1:0]                 way_be_o,
   output logic [`DC_WORD_W-1:0]                 way_wdat_o,
   input  logic [`DC_WORD_W-1:0]                 way0_rdat_i,
   input  logic [`DC_WORD_W-1:0]                 way1_rdat_i
);
   import dcache_pkg::*;

   dc_state_e state_q;
   dc_adr_t   req_adr;
   dc_adr_t   inv_adr;

   // Shared by dump reads and refill writes
   logic [`DC_WORDSEL_W-1:0] word_cnt_q;
   logic                     last_word;
   // Set being cleared; walks all sets after reset
   logic [`DC_INDEX_W-1:0]   clr_index_q;
   logic                     init_q;

   // Victim captured at the miss
   logic [`DC_WAYS-1:0]      victim_way_q;
   logic [`DC_TAG_W-1:0]     victim_tag_q;
   logic [`DC_WORD_W-1:0]    victim_rdat;
   // Dump read issued last cycle, and its word
   logic                     dump_rd_q;
   logic [`DC_WORDSEL_W-1:0] dump_cnt_q;

   logic hit;

   assign req_adr   = cpu_req_i.adr;
   assign inv_adr   = inv_adr_i;
   assign hit       = |hit_way_i;
   assign last_word = (word_cnt_q == `DC_WORDS_PER_BLOCK - 1);

   // ******************************
   // State machine
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= INVAL;
         init_q      <= 1'b1;
         clr_index_q <= '0;
         word_cnt_q  <= '0;
         dump_rd_q   <= 1'b0;
      end else begin
         dump_rd_q <= (state_q == DUMP);
         case (state_q)
            IDLE: begin
               // Invalidate wins over a pending request
               if (inv_stb_i) begin
                  clr_index_q <= inv_adr.index;
                  state_q     <= INVAL;
               end else if (cpu_req_valid_i) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               word_cnt_q <= '0;
               if (hit)
                  state_q <= IDLE;
               else if (victim_dirty_i)
                  state_q <= DUMP;
               else
                  state_q <= REFILL;
            end
            DUMP: begin
               // Counter wraps to zero for the refill
               word_cnt_q <= word_cnt_q + 1'b1;
               if (last_word)
                  state_q <= REFILL;
            end
            REFILL: begin
               if (refill_we_i) begin
                  word_cnt_q <= word_cnt_q + 1'b1;
                  // Back through IDLE, the retry then hits
                  if (last_word)
                     state_q <= IDLE;
               end
            end
            INVAL: begin
               clr_index_q <= clr_index_q + 1'b1;
               if (!init_q || clr_index_q == '1) begin
                  init_q  <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Victim and dump word registers
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP && !hit) begin
         victim_way_q <= victim_way_i;
         victim_tag_q <= victim_tag_i;
      end
      dump_cnt_q <= word_cnt_q;
   end

   // ******************************
   // Datapath and tag commands
   // ******************************
   always_comb begin
      cpu_ack_o      = 1'b0;
      tag_op_o       = TAG_NONE;
      tag_wr_index_o = req_adr.index;
      tag_way_o      = `DC_WAYS'(1);
      tag_new_tag_o  = req_adr.tag;
      tag_dirty_o    = 1'b0;
      way_we_o       = '0;
      way_wr_adr_o   = {req_adr.index, req_adr.word};
      way_be_o       = cpu_req_i.be;
      way_wdat_o     = cpu_req_i.wdat;
      case (state_q)
         LOOKUP: begin
            if (hit) begin
               cpu_ack_o   = 1'b1;
               tag_op_o    = TAG_TOUCH;
               tag_way_o   = hit_way_i;
               tag_dirty_o = cpu_req_i.we;
               // Store lands in the hit way only
               if (cpu_req_i.we)
                  way_we_o = hit_way_i;
            end
         end
         REFILL: begin
            way_wr_adr_o = {req_adr.index, word_cnt_q};
            way_be_o     = '1;
            way_wdat_o   = refill_dat_i;
            if (refill_we_i) begin
               way_we_o = victim_way_q;
               if (last_word) begin
                  tag_op_o  = TAG_FILL;
                  tag_way_o = victim_way_q;
               end
            end
         end
         INVAL: begin
            tag_op_o       = TAG_CLEAR;
            tag_wr_index_o = clr_index_q;
         end
         default: begin
         end
      endcase
   end

   assign tag_rd_index_o = req_adr.index;
   assign tag_cmp_tag_o  = req_adr.tag;
   // Dump walks the victim block, otherwise the requested word
   assign way_rd_adr_o   = (state_q == DUMP) ? {req_adr.index, word_cnt_q}
                                             : {req_adr.index, req_adr.word};

   assign cpu_rdat_o   = hit_way_i[1] ? way1_rdat_i : way0_rdat_i;
   assign victim_rdat  = victim_way_q[1] ? way1_rdat_i : way0_rdat_i;
   // Fourth beat leaves in the first REFILL cycle
   assign dump_valid_o = dump_rd_q;
   assign dump_o       = '{adr: {victim_tag_q, req_adr.index, dump_cnt_q, 2'b00},
                           dat: victim_rdat};

   assign refill_req_o = (state_q == REFILL);
   assign refill_adr_o = {req_adr.tag, req_adr.index, {`DC_OFFSET_W{1'b0}}};
   // Reset sweep is not acknowledged
   assign inv_ack_o    = (state_q == INVAL) && !init_q;

   // Hit way and victim way both come from the tag array
   a_we_single: assert property (@(posedge clk) disable iff (rst) !(&way_we_o));

   a_refill_in_state: assert property (@(posedge clk) disable iff (rst)
      refill_we_i |-> (state_q == REFILL));

endmodule

//--- hw/dcache_top.sv
/*
 2-way write-back data cache, 16 sets of 16-byte blocks.
 The CPU holds its request until ack; a hit acks one cycle
 after it is sampled. Dump beats have no back-pressure.
*/
`include "dcache_config.svh"

module dcache_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cpu_req_valid_i,
   input  dcache_pkg::dc_cpu_req_t    cpu_req_i,
   output logic                       cpu_ack_o,
   output logic [`DC_WORD_W-1:0]      cpu_rdat_o,
   output logic                       dump_valid_o,
   output dcache_pkg::dc_dump_beat_t  dump_o,
   output logic                       refill_req_o,
   output logic [`DC_WORD_W-1:0]      refill_adr_o,
   input  logic                       refill_we_i,
   input  logic [`DC_WORD_W-1:0]      refill_dat_i,
   input  logic                       inv_stb_i,
   input  logic [`DC_WORD_W-1:0]      inv_adr_i,
   output logic                       inv_ack_o
);
   import dcache_pkg::*;

   // Controller to tag array
   logic [`DC_INDEX_W-1:0] tag_rd_index;
   logic [`DC_TAG_W-1:0]   tag_cmp_tag;
   dc_tag_op_e             tag_op;
   logic [`DC_INDEX_W-1:0] tag_wr_index;
   logic [`DC_WAYS-1:0]    tag_way;
   logic [`DC_TAG_W-1:0]   tag_new_tag;
   logic                   tag_dirty;
   // Tag array to controller
   logic [`DC_WAYS-1:0]    hit_way;
   logic [`DC_WAYS-1:0]    victim_way;
   logic                   victim_dirty;
   logic [`DC_TAG_W-1:0]   victim_tag;

   // Data ways share everything but write enable and read data
   logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0] way_rd_adr;
   logic [`DC_WAYS-1:0]                  way_we;
   logic [`DC_INDEX_W+`DC_WORDSEL_W-1:0] way_wr_adr;
   logic [`DC_BSEL_W-1:0]                way_be;
   logic [`DC_WORD_W-1:0]                way_wdat;
   logic [`DC_WORD_W-1:0]                way0_rdat;
   logic [`DC_WORD_W-1:0]                way1_rdat;

   dcache_ctrl u_ctrl (
      .clk (clk), .rst (rst),
      .cpu_req_valid_i (cpu_req_valid_i), .cpu_req_i (cpu_req_i),
      .cpu_ack_o (cpu_ack_o), .cpu_rdat_o (cpu_rdat_o),
      .dump_valid_o (dump_valid_o), .dump_o (dump_o),
      .refill_req_o (refill_req_o), .refill_adr_o (refill_adr_o),
      .refill_we_i (refill_we_i), .refill_dat_i (refill_dat_i),
      .inv_stb_i (inv_stb_i), .inv_adr_i (inv_adr_i), .inv_ack_o (inv_ack_o),
      .tag_rd_index_o (tag_rd_index), .tag_cmp_tag_o (tag_cmp_tag),
      .tag_op_o (tag_op), .tag_wr_index_o (tag_wr_index), .tag_way_o (tag_way),
      .tag_new_tag_o (tag_new_tag), .tag_dirty_o (tag_dirty),
      .hit_way_i (hit_way), .victim_way_i (victim_way),
      .victim_dirty_i (victim_dirty), .victim_tag_i (victim_tag),
      .way_rd_adr_o (way_rd_adr), .way_we_o (way_we), .way_wr_adr_o (way_wr_adr),
      .way_be_o (way_be), .way_wdat_o (way_wdat),
      .way0_rdat_i (way0_rdat), .way1_rdat_i (way1_rdat)
   );

   dcache_tag_array u_tags (
      .clk (clk),
      .rd_index_i (tag_rd_index), .cmp_tag_i (tag_cmp_tag), .op_i (tag_op),
      .wr_index_i (tag_wr_index), .way_i (tag_way), .new_tag_i (tag_new_tag),
      .dirty_i (tag_dirty),
      .hit_way_o (hit_way), .victim_way_o (victim_way),
      .victim_dirty_o (victim_dirty), .victim_tag_o (victim_tag)
   );

   dcache_data_way u_way0 (
      .clk (clk), .rd_adr_i (way_rd_adr), .we_i (way_we[0]),
      .wr_adr_i (way_wr_adr), .be_i (way_be), .wdat_i (way_wdat),
      .rd_dat_o (way0_rdat)
   );

   dcache_data_way u_way1 (
      .clk (clk), .rd_adr_i (way_rd_adr), .we_i (way_we[1]),
      .wr_adr_i (way_wr_adr), .be_i (way_be), .wdat_i (way_wdat),
      .rd_dat_o (way1_rdat)
   );

endmodule

//--- verif/tb_clkgen.sv
/*
 Clock and reset source for the testbench. Period is 10 time
 units. Reset is high for RST_CYCLES rising edges and is
 released on a falling edge.
*/
module tb_clkgen #(
   parameter int RST_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // Release away from the sampling edge
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

//--- verif/tb_checker.sv
/*
 Scoreboard for the data cache. Keeps its own image of the
 1024-word memory, filled with the same pattern as the backing
 memory. Samples at the rising edge; inputs change mid-cycle.
 Invalidating a dirty set makes the image stale.
*/
module tb_checker (
   input  logic                       clk,
   input  logic                       rst,
   input  dcache_pkg::dc_cpu_req_t    cpu_req_i,
   input  logic                       cpu_ack_i,
   input  logic [31:0]                cpu_rdat_i,
   input  logic                       dump_valid_i,
   input  dcache_pkg::dc_dump_beat_t  dump_i,
   input  logic                       refill_req_i,
   input  logic [31:0]                refill_adr_i,
   output int                         check_cnt_o,
   output int                         err_cnt_o
);
   import dcache_pkg::*;

   logic [31:0] gold [1024];
   int          checks;
   int          errors;
   // Beats seen in the current dump burst
   int          beat_cnt;
   logic        refill_q;

   assign check_cnt_o = checks;
   assign err_cnt_o   = errors;

   // Power-up contents, every address bit shows up
   function automatic logic [31:0] fill_word(input logic [9:0] idx);
      return {6'h2d, idx, ~idx, idx[5:0]};
   endfunction

   // Reference model of a load
   function automatic logic [31:0] expected_read(input dc_adr_t adr);
      return gold[adr[11:2]];
   endfunction

   // Store semantics, enabled lanes take the new byte
   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] wdat,
                                               input logic [3:0]  be);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b])
            res[8*b +: 8] = wdat[8*b +: 8];
      end
      return res;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail t=%0t %s exp=%h got=%h", $time, name, exp, got);
      end
   endtask

   // ******************************
   // Compare process
   // ******************************
   initial begin
      checks   = 0;
      errors   = 0;
      beat_cnt = 0;
      refill_q = 1'b0;
      for (int i = 0; i < 1024; i++)
         gold[i] = fill_word(10'(i));
      forever begin
         @(posedge clk);
         if (rst) begin
            beat_cnt = 0;
            refill_q = 1'b0;
         end else begin
            // Victim words leave in address order within the request's set
            if (dump_valid_i) begin
               compare_word("dump_o.adr[7:0]",
                            {24'h0, cpu_req_i.adr.index, 2'(beat_cnt), 2'b00},
                            {24'h0, dump_i.adr[7:0]});
               compare_word("dump_o.dat", gold[dump_i.adr[11:2]], dump_i.dat);
               beat_cnt++;
            end
            // Start of a refill closes any dump burst
            if (refill_req_i && !refill_q) begin
               if (beat_cnt != 0 && beat_cnt != 4) begin
                  errors++;
                  $display("Dump burst ended after %0d beats instead of 4 at %0t",
                           beat_cnt, $time);
               end
               beat_cnt = 0;
               compare_word("refill_adr_o", {cpu_req_i.adr[31:4], 4'h0}, refill_adr_i);
            end
            refill_q = refill_req_i;
            if (cpu_ack_i) begin
               if (cpu_req_i.we)
                  gold[cpu_req_i.adr[11:2]] = merge_bytes(gold[cpu_req_i.adr[11:2]],
                                                          cpu_req_i.wdat, cpu_req_i.be);
               else
                  compare_word("cpu_rdat_o", expected_read(cpu_req_i.adr), cpu_rdat_i);
            end
         end
      end
   end

endmodule

//--- verif/tb_top.sv
/*
 Testbench top for the data cache. Inputs change on the falling
 edge. Backing memory is 1024 words, so only address bits 11:0
 are used. Refill words come back after random gaps of 0 to 3
 cycles. Scenario checks are here, data checks in the checker.
*/
module tb_top;
   import dcache_pkg::*;

   localparam int TMO      = 200;
   localparam int RAND_OPS = 2000;

   logic          clk;
   logic          rst;
   logic          cpu_req_valid;
   dc_cpu_req_t   cpu_req;
   logic          cpu_ack;
   logic [31:0]   cpu_rdat;
   logic          dump_valid;
   dc_dump_beat_t dump;
   logic          refill_req;
   logic [31:0]   refill_adr;
   logic          refill_we;
   logic [31:0]   refill_dat;
   logic          inv_stb;
   logic [31:0]   inv_adr;
   logic          inv_ack;

   logic [31:0]   mem [1024];
   logic [2:0]    beat;
   int            gap;

   // Outcome of the last access
   int            lat;
   logic          saw_refill;
   logic          saw_dump;
   // Address of the first dump beat of the last access
   logic [31:0]   first_dump_adr;

   int            scen_err;
   int            tmo_cnt;
   int            check_cnt;
   int            err_cnt;

   tb_clkgen #(.RST_CYCLES(8)) clkgen_i (.clk_o(clk), .rst_o(rst));

   dcache_top dcache_top_i (
      .clk (clk), .rst (rst),
      .cpu_req_valid_i (cpu_req_valid), .cpu_req_i (cpu_req),
      .cpu_ack_o (cpu_ack), .cpu_rdat_o (cpu_rdat),
      .dump_valid_o (dump_valid), .dump_o (dump),
      .refill_req_o (refill_req), .refill_adr_o (refill_adr),
      .refill_we_i (refill_we), .refill_dat_i (refill_dat),
      .inv_stb_i (inv_stb), .inv_adr_i (inv_adr), .inv_ack_o (inv_ack)
   );

   tb_checker chk_i (
      .clk (clk), .rst (rst),
      .cpu_req_i (cpu_req), .cpu_ack_i (cpu_ack), .cpu_rdat_i (cpu_rdat),
      .dump_valid_i (dump_valid), .dump_i (dump),
      .refill_req_i (refill_req), .refill_adr_i (refill_adr),
      .check_cnt_o (check_cnt), .err_cnt_o (err_cnt)
   );

   // Same power-up pattern as the checker's image
   function automatic logic [31:0] fill_word(input logic [9:0] idx);
      return {6'h2d, idx, ~idx, idx[5:0]};
   endfunction

   function automatic logic [31:0] make_adr(input logic [3:0] tag, input logic [3:0] set,
                                            input logic [1:0] word);
      return {20'h0, tag, set, word, 2'b00};
   endfunction

   // ******************************
   // Backing memory
   // ******************************
   initial begin
      refill_we  = 1'b0;
      refill_dat = '0;
      beat       = '0;
      gap        = 0;
      for (int i = 0; i < 1024; i++)
         mem[i] = fill_word(10'(i));
      forever begin
         @(negedge clk);
         refill_we = 1'b0;
         // Dump beats always accepted
         if (dump_valid)
            mem[dump.adr[11:2]] = dump.dat;
         if (!refill_req) begin
            beat = '0;
         end else if (beat < 3'd4) begin
            if (gap > 0) begin
               gap--;
            end else begin
               refill_we  = 1'b1;
               refill_dat = mem[{refill_adr[11:4], beat[1:0]}];
               beat++;
               gap = $urandom_range(3, 0);
            end
         end
      end
   end

   // ******************************
   // Handshake tasks
   // ******************************
   task automatic expect_true(input logic cond, input string what);
      if (!cond) begin
         scen_err++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   // First victim word must belong to the least recently used block
   task automatic compare_dump_adr(input logic [31:0] exp);
      if (saw_dump && first_dump_adr !== exp) begin
         scen_err++;
         $display("Fail t=%0t dump_o.adr exp=%h got=%h", $time, exp, first_dump_adr);
      end
   endtask

   task automatic wait_reset_done();
      int n;
      n = 0;
      while (rst !== 1'b0 && n < TMO) begin
         @(negedge clk);
         n++;
      end
      if (rst !== 1'b0) begin
         tmo_cnt++;
         $display("Timeout: reset was never released");
      end
   endtask

   // Request is held until ack and then only valid drops
   task automatic cpu_access(input logic we, input logic [31:0] adr,
                             input logic [3:0] be, input logic [31:0] wdat);
      int n;
      n = 0;
      saw_refill     = 1'b0;
      saw_dump       = 1'b0;
      first_dump_adr = '0;
      @(negedge clk);
      cpu_req.adr   = adr;
      cpu_req.we    = we;
      cpu_req.be    = be;
      cpu_req.wdat  = wdat;
      cpu_req_valid = 1'b1;
      do begin
         @(negedge clk);
         n++;
         if (dump_valid && !saw_dump)
            first_dump_adr = dump.adr;
         saw_refill = saw_refill | refill_req;
         saw_dump   = saw_dump | dump_valid;
      end while (!cpu_ack && n < TMO);
      cpu_req_valid = 1'b0;
      lat = n;
      if (!cpu_ack) begin
         tmo_cnt++;
         $display("Timeout: access to %h got no cpu_ack_o in %0d cycles", adr, TMO);
      end
   endtask

   task automatic invalidate(input logic [31:0] adr);
      int n;
      n = 0;
      @(negedge clk);
      inv_adr = adr;
      inv_stb = 1'b1;
      do begin
         @(negedge clk);
         n++;
      end while (!inv_ack && n < TMO);
      inv_stb = 1'b0;
      if (!inv_ack) begin
         tmo_cnt++;
         $display("Timeout: invalidate of %h got no inv_ack_o in %0d cycles", adr, TMO);
      end else begin
         expect_true(n == 1, "inv_ack_o did not come one cycle after sampling");
      end
   endtask

   // ******************************
   // Scenarios
   // ******************************
   task automatic run_directed();
      logic [31:0] a;
      // Read miss followed by a hit on the same word
      a = make_adr(4'h1, 4'h2, 2'd1);
      cpu_access(1'b0, a, 4'h0, '0);
      expect_true(saw_refill, "first read of a block raised no refill_req_o");
      cpu_access(1'b0, a, 4'h0, '0);
      expect_true(!saw_refill, "read hit raised refill_req_o");
      if (lat != 1) begin
         scen_err++;
         $display("Fail t=%0t cpu_ack_o latency exp=1 got=%0d", $time, lat);
      end
      // Byte lane merges on a resident block
      for (int i = 0; i < 8; i++) begin
         a = make_adr(4'h1, 4'h2, 2'(i));
         cpu_access(1'b1, a, 4'($urandom()), $urandom());
         cpu_access(1'b0, a, 4'h0, '0);
      end
      // Three dirty tags in set 5 so the third evicts the first
      cpu_access(1'b1, make_adr(4'h3, 4'h5, 2'd0), 4'hf, 32'hcafe_0003);
      cpu_access(1'b1, make_adr(4'h4, 4'h5, 2'd1), 4'h3, 32'h1234_5678);
      cpu_access(1'b1, make_adr(4'h6, 4'h5, 2'd2), 4'hc, 32'h8765_4321);
      expect_true(saw_dump, "dirty victim in set 5 was not dumped");
      // Tag 3 is the least recently used block of set 5
      compare_dump_adr(make_adr(4'h3, 4'h5, 2'd0));
      cpu_access(1'b0, make_adr(4'h3, 4'h5, 2'd0), 4'h0, '0);
      expect_true(saw_dump && saw_refill, "reading back the evicted line gave no dump and refill");
      // Tag 4 has now gone longest without an access
      compare_dump_adr(make_adr(4'h4, 4'h5, 2'd0));
      // Set 9 is only read and its victims stay clean
      cpu_access(1'b0, make_adr(4'h1, 4'h9, 2'd0), 4'h0, '0);
      cpu_access(1'b0, make_adr(4'h2, 4'h9, 2'd1), 4'h0, '0);
      cpu_access(1'b0, make_adr(4'h7, 4'h9, 2'd2), 4'h0, '0);
      expect_true(saw_refill && !saw_dump, "clean victim in set 9 was dumped");
      invalidate(make_adr(4'h7, 4'h9, 2'd0));
      cpu_access(1'b0, make_adr(4'h7, 4'h9, 2'd3), 4'h0, '0);
      expect_true(saw_refill, "read after invalidate hit a stale line");
   endtask

   task automatic run_random();
      int i;
      i = 0;
      while (i < RAND_OPS && tmo_cnt == 0) begin
         cpu_access(1'($urandom()), {20'h0, 10'($urandom()), 2'b00},
                    4'($urandom()), $urandom());
         i++;
      end
   endtask

   // ******************************
   // Main sequence
   // ******************************
   initial begin
      cpu_req_valid  = 1'b0;
      cpu_req        = '0;
      inv_stb        = 1'b0;
      inv_adr        = '0;
      scen_err       = 0;
      tmo_cnt        = 0;
      lat            = 0;
      saw_refill     = 1'b0;
      saw_dump       = 1'b0;
      first_dump_adr = '0;
      void'($urandom(32'hf848_2df8));
      wait_reset_done();
      if (tmo_cnt == 0)
         run_directed();
      if (tmo_cnt == 0)
         run_random();
      // Let the checker see the last ack
      repeat (2) @(negedge clk);
      $display("Summary: %0d data checks, %0d data errors, %0d scenario errors, %0d timeouts",
               check_cnt, err_cnt, scen_err, tmo_cnt);
      if (err_cnt == 0 && scen_err == 0 && tmo_cnt == 0 && check_cnt > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_way.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
# The verdict comes from the simulation log.

LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f tb.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
   echo "No verdict found in $LOG"
   exit 1
fi
exit 0
